/* addSubUnit.f */
+incdir+logic
logic/addSubPkg.sv
logic/prefixAndOrCfast.sv
logic/prefixAdder.sv
logic/operandStage.sv
logic/sumStage.sv
logic/flagStage.sv
logic/addSubUnit.sv
tb/addSubUnit_chk.sv
tb/addSubUnit_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' addSubUnit.f)
HDRS := logic/addsub_params.svh

obj_dir/VaddSubUnit_tb: addSubUnit.f $(SRCS) $(HDRS)
	verilator --binary --assert --timescale 1ns/10ps -f addSubUnit.f \
		--top-module addSubUnit_tb -o VaddSubUnit_tb

run: obj_dir/VaddSubUnit_tb
	./obj_dir/VaddSubUnit_tb > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* tb/addSubUnit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "addsub_params.svh"

module addSubUnit_tb;

	import addSubPkg::*;

	localparam int W = `ADDSUB_WIDTH;
	localparam word_t maxPos = {1'b0, {(W-1){1'b1}}}; // largest signed value
	localparam word_t minNeg = {1'b1, {(W-1){1'b0}}}; // most negative value

	logic    clk;
	logic    rstN;
	logic    inStrobe;
	word_t   opA;
	word_t   opB;
	opcode_t opcode;
	logic    carryIn;
	logic    outStrobe;
	word_t   result;
	logic    carryOut;
	logic    overflow;
	logic    zero;
	logic    negative;

	logic [W+3:0] expQ[$]; // {result, carry, overflow, zero, negative}, oldest first
	int seed;
	int errors;
	int checks;

	addSubUnit dut (
		.clk(clk),
		.rstN(rstN),
		.inStrobe(inStrobe),
		.opA(opA),
		.opB(opB),
		.opcode(opcode),
		.carryIn(carryIn),
		.outStrobe(outStrobe),
		.result(result),
		.carryOut(carryOut),
		.overflow(overflow),
		.zero(zero),
		.negative(negative)
	);

	always #5 clk = ~clk; // 10 ns period

	// reference model on wide sums, no prefix structure involved
	function automatic logic [W+3:0] predict(input word_t a, input word_t b,
			input opcode_t op, input logic cin);
		logic [W:0] uSum; // top bit is carry, or borrow on subtract
		logic [W:0] sSum; // sign extended operands
		logic       cUse;
		cUse = op[`ADDSUB_OP_CARRY_BIT] & cin;
		if (op[`ADDSUB_OP_SUB_BIT]) begin
			uSum = {1'b0, a} - {1'b0, b} - (W+1)'(cUse);
			sSum = {a[W-1], a} - {b[W-1], b} - (W+1)'(cUse);
		end else begin
			uSum = {1'b0, a} + {1'b0, b} + (W+1)'(cUse);
			sSum = {a[W-1], a} + {b[W-1], b} + (W+1)'(cUse);
		end
		// overflow when the signed sum leaves the word range
		return {uSum[W-1:0], uSum[W], sSum[W] ^ sSum[W-1], uSum[W-1:0] == '0, uSum[W-1]};
	endfunction

	function automatic word_t randWord();
		logic [31:0] r;
		r = $random(seed);
		return r[W-1:0];
	endfunction

	// a few steps from zero or from all ones
	function automatic word_t nearEdge();
		word_t r;
		r = randWord();
		return r[3] ? ~word_t'(r[2:0]) : word_t'(r[2:0]);
	endfunction

	task compareValue(input string name, input word_t want, input word_t got);
		checks++;
		assert (got === want) else begin
			$display("Fail %s expected %h actual %h", name, want, got);
			errors++;
		end
	endtask

	// strobe stays high until endReqs, so calls in a row go back to back
	task sendReq(input word_t a, input word_t b, input opcode_t op, input logic cin);
		@(posedge clk);
		#1;
		inStrobe = 1'b1;
		opA      = a;
		opB      = b;
		opcode   = op;
		carryIn  = cin;
		expQ.push_back(predict(a, b, op, cin));
	endtask

	task endReqs();
		@(posedge clk);
		#1;
		inStrobe = 1'b0;
	endtask

	task waitOut(output logic got);
		int n;
		got = 1'b0;
		n   = 0;
		while (!got && n < 20) begin
			@(negedge clk);
			got = outStrobe;
			n++;
		end
		if (!got) begin
			$display("Error: no output strobe within 20 cycles");
			errors++;
		end
	endtask

	task drainQueue();
		int n;
		n = 0;
		while (expQ.size() != 0 && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (expQ.size() != 0) begin
			$display("Error: %0d results never came out of the unit", expQ.size());
			errors++;
			expQ.delete();
		end
	endtask

	// two-word operation, low carry or borrow feeds the high word
	task chainPair(input logic [2*W-1:0] a, input logic [2*W-1:0] b, input logic sub,
			input logic cin);
		logic [2*W:0] wide;
		opcode_t      op;
		word_t        loRes;
		logic         loCarry;
		logic         got;
		op = sub ? `ADDSUB_OP_SUBB : `ADDSUB_OP_ADDC;
		if (sub) wide = {1'b0, a} - {1'b0, b} - (2*W+1)'(cin);
		else     wide = {1'b0, a} + {1'b0, b} + (2*W+1)'(cin);
		sendReq(a[W-1:0], b[W-1:0], op, cin);
		endReqs();
		waitOut(got);
		loRes   = result;
		loCarry = carryOut;
		sendReq(a[2*W-1:W], b[2*W-1:W], op, loCarry);
		endReqs();
		waitOut(got);
		if (got) begin
			checks++;
			assert ({carryOut, result, loRes} === wide) else begin
				$display("Fail chain {carryOut, result} expected %h actual %h",
				         wide, {carryOut, result, loRes});
				errors++;
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		logic [W+3:0] want;
		if (!rstN) begin
			checks++;
			assert (!outStrobe) else begin
				$display("Error: outStrobe high during reset");
				errors++;
			end
		end else if (outStrobe) begin
			if (expQ.size() == 0) begin
				$display("Error: outStrobe without a pending request");
				errors++;
			end else begin
				want = expQ.pop_front();
				compareValue("result", want[W+3:4], result);
				compareValue("carryOut", word_t'(want[3]), word_t'(carryOut));
				compareValue("overflow", word_t'(want[2]), word_t'(overflow));
				compareValue("zero", word_t'(want[1]), word_t'(zero));
				compareValue("negative", word_t'(want[0]), word_t'(negative));
			end
		end
	end

	initial begin
		word_t a;
		word_t b;
		word_t r;
		clk      = 1'b0;
		rstN     = 1'b0;
		inStrobe = 1'b0;
		opA      = '0;
		opB      = '0;
		opcode   = `ADDSUB_OP_ADD;
		carryIn  = 1'b0;
		seed     = 27738;
		errors   = 0;
		checks   = 0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		repeat (4) @(posedge clk); // idle, nothing may come out

		for (int i = 0; i < 2000; i++) begin // random mix with idle gaps
			a = randWord();
			b = randWord();
			r = randWord();
			sendReq(a, b, r[1:0], r[2]);
			if (r[5:3] == 3'd0) endReqs();
		end
		endReqs();
		drainQueue();

		for (int i = 0; i < 300; i++) begin // carry and borrow near the edges
			r = randWord();
			sendReq(nearEdge(), nearEdge(), r[1:0], r[2]);
		end
		endReqs();
		drainQueue();

		for (int i = 0; i < 100; i++) begin
			r = randWord();
			chainPair({randWord(), randWord()}, {randWord(), randWord()}, r[0], r[1]);
		end
		drainQueue();

		// sign rule corners
		a = randWord();
		sendReq(minNeg, word_t'(1), `ADDSUB_OP_SUB, 1'b0);
		sendReq(maxPos, word_t'(1), `ADDSUB_OP_ADD, 1'b0);
		sendReq(a, a, `ADDSUB_OP_SUB, 1'b0);
		sendReq(a, a, `ADDSUB_OP_SUBB, 1'b1); // minus one, borrow out
		sendReq('1, word_t'(1), `ADDSUB_OP_ADD, 1'b0);
		sendReq(minNeg, minNeg, `ADDSUB_OP_ADD, 1'b0);
		sendReq('0, word_t'(1), `ADDSUB_OP_SUB, 1'b0);
		sendReq(maxPos, '1, `ADDSUB_OP_SUB, 1'b0);
		endReqs();
		drainQueue();

		for (int i = 0; i < 64; i++) begin // strobe held high throughout
			r = randWord();
			sendReq(randWord(), randWord(), r[1:0], r[2]);
		end
		endReqs();
		drainQueue();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/addSubUnit_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module addSubUnit_chk (
	input logic clk,
	input logic rstN,
	input logic inStrobe,
	input logic outStrobe
);

	// strobe cleared by every reset edge
	resetQuiet: assert property (@(posedge clk) !rstN |=> !outStrobe)
		else $error("outStrobe high after a reset cycle");

	// pipe still empty one cycle after release
	releaseQuiet: assert property (@(posedge clk) $rose(rstN) |=> !outStrobe)
		else $error("outStrobe high right after reset release");

	// capture edge plus two register stages, seen one sample later
	strobeFollows: assert property (@(posedge clk) disable iff (!rstN)
		$past(inStrobe, 3) |-> outStrobe)
		else $error("request accepted but no output strobe two cycles later");

	noStrayStrobe: assert property (@(posedge clk) disable iff (!rstN)
		outStrobe |-> $past(inStrobe, 3))
		else $error("output strobe without a request two cycles before");

endmodule

bind addSubUnit addSubUnit_chk chk (
	.clk(clk),
	.rstN(rstN),
	.inStrobe(inStrobe),
	.outStrobe(outStrobe)
);

`default_nettype wire

/* logic/addSubUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module addSubUnit (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inStrobe,
	input  addSubPkg::word_t   opA,
	input  addSubPkg::word_t   opB,
	input  addSubPkg::opcode_t opcode,
	input  logic               carryIn,
	output logic               outStrobe, // two cycles after inStrobe
	output addSubPkg::word_t   result,
	output logic               carryOut,
	output logic               overflow,
	output logic               zero,
	output logic               negative
);

	import addSubPkg::*;

	// operand stage to sum stage
	logic  condValid;
	word_t condA;
	word_t condB;
	logic  condCarry;
	logic  condSub;

	// sum stage to flag stage
	logic  sumValid;
	word_t sumWord;
	logic  sumCarry;
	logic  sumSignA;
	logic  sumSignB;
	logic  sumSub;

	operandStage inStage (
		.clk(clk),
		.rstN(rstN),
		.inStrobe(inStrobe),
		.opA(opA),
		.opB(opB),
		.opcode(opcode),
		.carryIn(carryIn),
		.condValid(condValid),
		.condA(condA),
		.condB(condB),
		.condCarry(condCarry),
		.condSub(condSub)
	);

	sumStage midStage (
		.clk(clk),
		.rstN(rstN),
		.condValid(condValid),
		.condA(condA),
		.condB(condB),
		.condCarry(condCarry),
		.condSub(condSub),
		.sumValid(sumValid),
		.sumWord(sumWord),
		.sumCarry(sumCarry),
		.sumSignA(sumSignA),
		.sumSignB(sumSignB),
		.sumSub(sumSub)
	);

	flagStage outStage (
		.clk(clk),
		.rstN(rstN),
		.sumValid(sumValid),
		.sumWord(sumWord),
		.sumCarry(sumCarry),
		.sumSignA(sumSignA),
		.sumSignB(sumSignB),
		.sumSub(sumSub),
		.outStrobe(outStrobe),
		.result(result),
		.carryOut(carryOut),
		.overflow(overflow),
		.zero(zero),
		.negative(negative)
	);

endmodule

`default_nettype wire

/* logic/flagStage.sv */
`timescale 1ns/10ps
`default_nettype none

module flagStage (
	input  logic             clk,
	input  logic             rstN,
	input  logic             sumValid,
	input  addSubPkg::word_t sumWord,
	input  logic             sumCarry,
	input  logic             sumSignA,
	input  logic             sumSignB,
	input  logic             sumSub,
	output logic             outStrobe, // one cycle per request
	output addSubPkg::word_t result,
	output logic             carryOut,  // carry on add, borrow on subtract
	output logic             overflow,  // signed overflow
	output logic             zero,
	output logic             negative
);

	import addSubPkg::*;

	localparam int msb = $bits(word_t) - 1;

	logic nextCarry;
	logic nextOverflow;
	logic nextZero;

	// subtract borrows when the adder did not carry
	assign nextCarry = sumSub ? ~sumCarry : sumCarry;

	// same operand signs, different result sign
	assign nextOverflow = (sumSignA == sumSignB) && (sumWord[msb] != sumSignA);

	assign nextZero = (sumWord == '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outStrobe <= 1'b0;
		end else begin
			outStrobe <= sumValid; // high for exactly one cycle
		end
	end

	always_ff @(posedge clk) begin
		if (sumValid) begin
			result   <= sumWord;
			carryOut <= nextCarry;
			overflow <= nextOverflow;
			zero     <= nextZero;
			negative <= sumWord[msb]; // sign of the result
		end
	end

endmodule

`default_nettype wire

/* logic/sumStage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "addsub_params.svh"

module sumStage (
	input  logic             clk,
	input  logic             rstN,
	input  logic             condValid, // conditioned operands valid
	input  addSubPkg::word_t condA,
	input  addSubPkg::word_t condB,
	input  logic             condCarry,
	input  logic             condSub,
	output logic             sumValid,
	output addSubPkg::word_t sumWord,
	output logic             sumCarry,  // raw adder carry out
	output logic             sumSignA,  // msb of a
	output logic             sumSignB,  // msb of conditioned b
	output logic             sumSub
);

	import addSubPkg::*;

	localparam int msb = $bits(word_t) - 1;

	word_t addSum;   // adder result, combinational
	logic  addCarry;

	prefixAdder #(
		.width(`ADDSUB_WIDTH),
		.speed(`ADDSUB_SPEED)
	) adder (
		.a(condA),
		.b(condB),
		.ci(condCarry),
		.s(addSum),
		.co(addCarry)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			sumValid <= 1'b0;
		end else begin
			sumValid <= condValid;
		end
	end

	always_ff @(posedge clk) begin
		if (condValid) begin
			sumWord  <= addSum;
			sumCarry <= addCarry;
			sumSignA <= condA[msb]; // signs for overflow one stage later
			sumSignB <= condB[msb]; // already inverted on subtract
			sumSub   <= condSub;
		end
	end

endmodule

`default_nettype wire

/* logic/operandStage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "addsub_params.svh"

module operandStage (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inStrobe,  // request this cycle
	input  addSubPkg::word_t   opA,
	input  addSubPkg::word_t   opB,
	input  addSubPkg::opcode_t opcode,
	input  logic               carryIn,   // carry, or borrow for subb
	output logic               condValid,
	output addSubPkg::word_t   condA,
	output addSubPkg::word_t   condB,     // inverted for subtraction
	output logic               condCarry, // adder carry in
	output logic               condSub    // subtract flag for the flags
);

	import addSubPkg::*;

	logic  isSub;     // opcode bit 0
	word_t nextB;
	logic  nextCarry;

	assign isSub = opcode[`ADDSUB_OP_SUB_BIT];
	assign nextB = isSub ? ~opB : opB; // a - b = a + ~b + 1

	always_comb begin
		case (opcode)
			`ADDSUB_OP_ADD:  nextCarry = 1'b0;
			`ADDSUB_OP_SUB:  nextCarry = 1'b1;     // the +1 of two's complement
			`ADDSUB_OP_ADDC: nextCarry = carryIn;
			`ADDSUB_OP_SUBB: nextCarry = ~carryIn; // borrow set drops the +1
			default:         nextCarry = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			condValid <= 1'b0;
		end else begin
			condValid <= inStrobe; // one cycle strobe follows the data
		end
	end

	always_ff @(posedge clk) begin
		if (inStrobe) begin
			condA     <= opA;
			condB     <= nextB;
			condCarry <= nextCarry;
			condSub   <= isSub;
		end
	end

endmodule

`default_nettype wire

/* logic/prefixAdder.sv */
`timescale 1ns/10ps
`default_nettype none

// {co, s} = a + b + ci
module prefixAdder #(
	parameter int width = 16, // word width
	parameter int speed = 1   // prefix structure select
) (
	input  logic [width-1:0] a,  // operands
	input  logic [width-1:0] b,
	input  logic             ci, // carry in
	output logic [width-1:0] s,  // sum
	output logic             co  // carry out
);

	logic [width-1:0] bitG;  // per-bit generate
	logic [width-1:0] bitP;  // per-bit propagate, or form
	logic [width-1:0] halfS; // a xor b
	logic [width-1:0] grpG;  // carry into bit i+1

	assign bitG  = a & b;
	assign bitP  = a | b;   // or-propagate is enough for carries
	assign halfS = ~bitG & bitP;

	prefixAndOrCfast #(
		.width(width),
		.speed(speed)
	) tree (
		.gi(bitG),
		.pi(bitP),
		.ci(ci),
		.go(grpG),
		.po()     // group propagate not needed here
	);

	// carry into bit 0 is ci itself
	assign s  = halfS ^ {grpG[width-2:0], ci};
	assign co = grpG[width-1];

endmodule

`default_nettype wire

/* logic/prefixAndOrCfast.sv */
`timescale 1ns/10ps
`default_nettype none

module prefixAndOrCfast #(
	parameter int width = 16, // word width
	parameter int speed = 1   // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] gi, // bit generate
	input  logic [width-1:0] pi, // bit propagate
	input  logic             ci, // carry in
	output logic [width-1:0] go, // group generate incl. carry in
	output logic [width-1:0] po  // group propagate
);

	localparam int m = $clog2(width); // tree depth

	logic [width-1:0] treeG; // group generate, carry in not yet merged
	logic [width-1:0] treeP; // group propagate

	if (speed == 2) begin : sklansky
		logic [m:0][width-1:0] gL; // one row per level
		logic [m:0][width-1:0] pL;

		assign gL[0] = gi;
		assign pL[0] = pi;

		for (genvar l = 1; l <= m; l++) begin : lvl
			for (genvar i = 0; i < width; i++) begin : col
				// upper half of each 2**l block takes the top bit of the lower half
				if ((i / 2**(l-1)) % 2 == 1) begin : node
					localparam int src = (i / 2**l) * 2**l + 2**(l-1) - 1;
					assign gL[l][i] = gL[l-1][i] | (pL[l-1][i] & gL[l-1][src]);
					assign pL[l][i] = pL[l-1][i] & pL[l-1][src];
				end else begin : pass
					assign gL[l][i] = gL[l-1][i];
					assign pL[l][i] = pL[l-1][i];
				end
			end
		end

		assign treeG = gL[m];
		assign treeP = pL[m];
	end else if (speed == 1) begin : brentKung
		localparam int depth = 2*m - 1; // up sweep then down sweep

		logic [depth:0][width-1:0] gL;
		logic [depth:0][width-1:0] pL;

		assign gL[0] = gi;
		assign pL[0] = pi;

		// up sweep, builds power-of-two groups at the block tops
		for (genvar l = 1; l <= m; l++) begin : up
			for (genvar i = 0; i < width; i++) begin : col
				if ((i + 1) % 2**l == 0) begin : node
					assign gL[l][i] = gL[l-1][i] | (pL[l-1][i] & gL[l-1][i-2**(l-1)]);
					assign pL[l][i] = pL[l-1][i] & pL[l-1][i-2**(l-1)];
				end else begin : pass
					assign gL[l][i] = gL[l-1][i];
					assign pL[l][i] = pL[l-1][i];
				end
			end
		end

		// down sweep, fills the gaps from the finished prefixes
		for (genvar d = 1; d < m; d++) begin : down
			localparam int span = 2**(m-d); // block size at this level
			for (genvar i = 0; i < width; i++) begin : col
				if (((i + 1) % span == span/2) && (i >= span)) begin : node
					assign gL[m+d][i] = gL[m+d-1][i]
					                  | (pL[m+d-1][i] & gL[m+d-1][i-span/2]);
					assign pL[m+d][i] = pL[m+d-1][i] & pL[m+d-1][i-span/2];
				end else begin : pass
					assign gL[m+d][i] = gL[m+d-1][i];
					assign pL[m+d][i] = pL[m+d-1][i];
				end
			end
		end

		assign treeG = gL[depth];
		assign treeP = pL[depth];
	end else begin : serial
		logic [width-1:0] gC; // ripple chain
		logic [width-1:0] pC;

		assign gC[0] = gi[0];
		assign pC[0] = pi[0];

		for (genvar i = 1; i < width; i++) begin : col
			assign gC[i] = gi[i] | (pi[i] & gC[i-1]);
			assign pC[i] = pi[i] & pC[i-1];
		end

		assign treeG = gC;
		assign treeP = pC;
	end

	// fast carry in, one extra and-or level after the tree
	assign go = treeG | (treeP & {width{ci}});
	assign po = treeP; // unaffected by carry in

endmodule

`default_nettype wire

/* logic/addSubPkg.sv */
`default_nettype none

`include "addsub_params.svh"

// shared types of the add/subtract unit
package addSubPkg;

	// one operand or result word
	typedef logic [`ADDSUB_WIDTH-1:0] word_t;

	// operation code, see ADDSUB_OP_* in the params header
	typedef logic [1:0] opcode_t;

endpackage

`default_nettype wire

/* logic/addsub_params.svh */
`ifndef ADDSUB_PARAMS_SVH
`define ADDSUB_PARAMS_SVH

// datapath width in bits
// operands, sum and result all share it
`define ADDSUB_WIDTH 16

// prefix tree structure
// 0 serial ripple of prefix cells
// 1 Brent-Kung, log depth with few cells
// 2 Sklansky, minimum depth with high fanout
`define ADDSUB_SPEED 1

// opcode codes
// bit 0 set means subtract, bit 1 set means carry/borrow in is used
`define ADDSUB_OP_ADD  2'd0 // a + b
`define ADDSUB_OP_SUB  2'd1 // a - b
`define ADDSUB_OP_ADDC 2'd2 // a + b + carry
`define ADDSUB_OP_SUBB 2'd3 // a - b - borrow

// bit positions inside an opcode
`define ADDSUB_OP_SUB_BIT   0
`define ADDSUB_OP_CARRY_BIT 1

`endif
